/* all.f */
logic/rv_isa_pkg.sv
logic/rv_core_pkg.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_result.sv
logic/rv_pipe_top.sv
bench/tb_rv_pipe.sv

/* bench/rv_pipe_vectors.txt */
// columns: instruction, illegal flag, rd, expected value, all hex
// values follow sequential RV32I execution from a zeroed register file
00500093 0 01 00000005 // addi x1, x0, 5
FFD00113 0 02 FFFFFFFD // addi x2, x0, -3
800001B7 0 03 80000000 // lui x3, 0x80000
7FF00213 0 04 000007FF // addi x4, x0, 0x7ff
123452B7 0 05 12345000 // lui x5, 0x12345
00208333 0 06 00000002 // add x6, x1, x2
401303B3 0 07 FFFFFFFD // sub x7, x6, x1
00112433 0 08 00000001 // slt x8, x2, x1
001134B3 0 09 00000000 // sltu x9, x2, x1
4041D533 0 0A FFFFFFFF // sra x10, x3, x4
0041D5B3 0 0B 00000001 // srl x11, x3, x4
00409633 0 0C 80000000 // sll x12, x1, x4
0022C6B3 0 0D EDCBAFFD // xor x13, x5, x2
0046E733 0 0E EDCBAFFF // or x14, x13, x4
002777B3 0 0F EDCBAFFD // and x15, x14, x2
FFE12813 0 10 00000001 // slti x16, x2, -2
FFF0B893 0 11 00000001 // sltiu x17, x1, -1
FFF0C913 0 12 FFFFFFFA // xori x18, x1, -1
7000E993 0 13 00000705 // ori x19, x1, 0x700
0F097A13 0 14 000000F0 // andi x20, x18, 0xf0
00409A93 0 15 00000050 // slli x21, x1, 4
0041DB13 0 16 08000000 // srli x22, x3, 4
4041DB93 0 17 F8000000 // srai x23, x3, 4
00708013 0 00 0000000C // addi x0, x1, 7
00100C33 0 18 00000005 // add x24, x0, x1
02208333 1 00 00000000 // mul x6, x1, x2 is not supported
00030C93 0 19 00000002 // addi x25, x6, 0
0000A383 1 00 00000000 // lw x7, 0(x1) is not supported
40638D33 0 1A FFFFFFFB // sub x26, x7, x6
40409A93 1 00 00000000 // slli with funct7 0x20
001A8D93 0 1B 00000051 // addi x27, x21, 1
01BD8E33 0 1C 000000A2 // add x28, x27, x27
FFFFFF37 0 1E FFFFF000 // lui x30, 0xfffff
7FFF0F93 0 1F FFFFF7FF // addi x31, x30, 0x7ff

/* bench/tb_rv_pipe.sv */
`default_nettype none

module tb_rv_pipe;

    localparam int          CLK_PERIOD    = 40;
    localparam int          DRIVE_DLY     = 2;
    localparam int          RESET_CYCLES  = 5;
    localparam int          NUM_VEC       = 34;
    localparam int          VEC_WORDS     = 4 * NUM_VEC;
    localparam int          PIPE_LATENCY  = 3;
    localparam int          MAX_GAP       = 2;
    localparam int          DRAIN_TIMEOUT = 20;
    localparam logic [31:0] LCG_SEED      = 32'h9e41_dee8;

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        retire_valid;
    logic        retire_illegal;
    logic [4:0]  retire_rd;
    logic [31:0] retire_value;

    // four words per vector: instruction, illegal, rd, value
    logic [31:0] vec_mem [VEC_WORDS];

    // vectors in flight, oldest first
    int          pend_idx [$];
    int          pend_cycle [$];
    int          cycle_count = 0;
    logic [31:0] lcg_state;

    rv_pipe_top rv_pipe_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .retire_valid  (retire_valid),
        .retire_illegal(retire_illegal),
        .retire_rd     (retire_rd),
        .retire_value  (retire_value)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1, "testbench stopped at the first failure");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic pick_gap(output int gap);
        lcg_state = lcg_next(lcg_state);
        gap = int'(lcg_state[31:16]) % (MAX_GAP + 1);
    endtask

    // consumers that must follow their producers with no idle cycle
    function automatic logic must_chain(input int idx);
        case (idx)
            6, 13, 14, 18, 19, 24, 25, 26, 31, 33: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic drive_cycle(input logic valid, input logic [31:0] word);
        @(posedge clk);
        #DRIVE_DLY;
        inst_valid = valid;
        inst       = word;
    endtask

    task automatic issue_vector(input int idx);
        drive_cycle(1'b1, vec_mem[4 * idx]);
        pend_idx.push_back(idx);
        pend_cycle.push_back(cycle_count);
    endtask

    task automatic check_retire(input int idx, input int issued);
        logic        exp_illegal;
        logic [4:0]  exp_rd;
        logic [31:0] exp_value;
        exp_illegal = vec_mem[4 * idx + 1][0];
        exp_rd      = vec_mem[4 * idx + 2][4:0];
        exp_value   = vec_mem[4 * idx + 3];
        assert (cycle_count == issued + PIPE_LATENCY) else
            stop_with_failure($sformatf("[ERROR] %0t: vector %0d retired in cycle %0d, issued in %0d",
                                        $time, idx, cycle_count, issued));
        assert (retire_illegal === exp_illegal) else
            stop_with_failure($sformatf("[ERROR] %0t: vector %0d illegal %b, expected %b",
                                        $time, idx, retire_illegal, exp_illegal));
        assert (retire_rd === exp_rd) else
            stop_with_failure($sformatf("[ERROR] %0t: vector %0d rd %0d, expected %0d",
                                        $time, idx, retire_rd, exp_rd));
        assert (retire_value === exp_value) else
            stop_with_failure($sformatf("[ERROR] %0t: vector %0d value %h, expected %h",
                                        $time, idx, retire_value, exp_value));
    endtask

    // retire side, sampled mid-cycle
    always @(negedge clk) begin
        int idx;
        int issued;
        if (rst_n) begin
            assert (!$isunknown(retire_valid)) else
                stop_with_failure($sformatf("[ERROR] %0t: retire_valid is unknown", $time));
            if (retire_valid) begin
                assert (pend_idx.size() != 0) else
                    stop_with_failure($sformatf("[ERROR] %0t: retire with nothing in flight",
                                                $time));
                idx    = pend_idx.pop_front();
                issued = pend_cycle.pop_front();
                check_retire(idx, issued);
            end
            else if (pend_idx.size() != 0) begin
                assert (cycle_count <= pend_cycle[0] + PIPE_LATENCY) else
                    stop_with_failure($sformatf("[ERROR] %0t: vector %0d never retired",
                                                $time, pend_idx[0]));
            end
        end
    end

    initial begin
        int gap;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        lcg_state  = LCG_SEED;

        $readmemh("bench/rv_pipe_vectors.txt", vec_mem);
        assert (!$isunknown(vec_mem[VEC_WORDS - 1])) else
            stop_with_failure("the vector file could not be read completely");

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        // idle pipeline stays quiet
        repeat (4) begin
            drive_cycle(1'b0, '0);
            assert (retire_valid === 1'b0) else
                stop_with_failure($sformatf("[ERROR] %0t: retire_valid high before any issue",
                                            $time));
        end

        for (int i = 0; i < NUM_VEC; i++) begin
            if (must_chain(i)) begin
                gap = 0;
            end
            else begin
                pick_gap(gap);
            end
            repeat (gap) drive_cycle(1'b0, '0);
            issue_vector(i);
        end
        drive_cycle(1'b0, '0);

        for (int t = 0; t < DRAIN_TIMEOUT && pend_idx.size() != 0; t++) begin
            @(posedge clk);
        end
        assert (pend_idx.size() == 0) else
            stop_with_failure($sformatf("timed out with %0d instructions still waiting to retire",
                                        pend_idx.size()));

        // catch any stray retire after the last one
        repeat (PIPE_LATENCY + 1) @(posedge clk);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule : tb_rv_pipe

`default_nettype wire

/* logic/rv_pipe_top.sv */
`default_nettype none

module rv_pipe_top (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        inst_valid,
    input  wire rv_isa_pkg::inst_word_t inst,
    output logic                       retire_valid,
    output logic                       retire_illegal,
    output rv_core_pkg::reg_idx_t      retire_rd,
    output rv_core_pkg::word_t         retire_value
);
    import rv_core_pkg::*;

    // decode stage outputs
    logic     de_valid;
    logic     de_illegal;
    alu_op_t  de_alu_op;
    word_t    de_a;
    word_t    de_b;
    reg_idx_t de_rd;

    // execute stage outputs, also fed back for forwarding
    word_t    alu_result;
    logic     ex_valid;
    logic     ex_illegal;
    reg_idx_t ex_rd;
    word_t    ex_value;

    // register file read ports
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;

    rv_decode rv_decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_valid(inst_valid),
        .inst      (inst),
        .alu_result(alu_result),
        .ex_valid  (ex_valid),
        .ex_illegal(ex_illegal),
        .ex_rd     (ex_rd),
        .ex_value  (ex_value),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .de_valid  (de_valid),
        .de_illegal(de_illegal),
        .de_alu_op (de_alu_op),
        .de_a      (de_a),
        .de_b      (de_b),
        .de_rd     (de_rd)
    );

    rv_execute rv_execute_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .de_valid  (de_valid),
        .de_illegal(de_illegal),
        .de_alu_op (de_alu_op),
        .de_a      (de_a),
        .de_b      (de_b),
        .de_rd     (de_rd),
        .alu_result(alu_result),
        .ex_valid  (ex_valid),
        .ex_illegal(ex_illegal),
        .ex_rd     (ex_rd),
        .ex_value  (ex_value)
    );

    rv_result rv_result_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_valid      (ex_valid),
        .ex_illegal    (ex_illegal),
        .ex_rd         (ex_rd),
        .ex_value      (ex_value),
        .rs1_idx       (rs1_idx),
        .rs2_idx       (rs2_idx),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .retire_valid  (retire_valid),
        .retire_illegal(retire_illegal),
        .retire_rd     (retire_rd),
        .retire_value  (retire_value)
    );

endmodule : rv_pipe_top

`default_nettype wire

/* logic/rv_result.sv */
`default_nettype none

module rv_result (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        ex_valid,
    input  wire                        ex_illegal,
    input  wire rv_core_pkg::reg_idx_t ex_rd,
    input  wire rv_core_pkg::word_t    ex_value,
    input  wire rv_core_pkg::reg_idx_t rs1_idx,
    input  wire rv_core_pkg::reg_idx_t rs2_idx,
    output rv_core_pkg::word_t         rs1_data,
    output rv_core_pkg::word_t         rs2_data,
    output logic                       retire_valid,
    output logic                       retire_illegal,
    output rv_core_pkg::reg_idx_t      retire_rd,
    output rv_core_pkg::word_t         retire_value
);
    import rv_core_pkg::*;

    word_t regs [REG_COUNT];
    logic  wr_en;

    // x0 is hardwired, never written
    assign wr_en = ex_valid && !ex_illegal && (ex_rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end
        else if (wr_en) begin
            regs[ex_rd] <= ex_value;
        end
    end

    // combinational read ports for decode
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end
        else begin
            retire_valid <= ex_valid;
        end
    end

    // illegal retires report a zero value
    always_ff @(posedge clk) begin
        if (ex_valid) begin
            retire_illegal <= ex_illegal;
            retire_rd      <= ex_rd;
            retire_value   <= ex_illegal ? '0 : ex_value;
        end
    end

    illegal_retire_rd_zero : assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid && retire_illegal |-> retire_rd == '0);

endmodule : rv_result

`default_nettype wire

/* logic/rv_execute.sv */
`default_nettype none

module rv_execute (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        de_valid,
    input  wire                        de_illegal,
    input  wire rv_core_pkg::alu_op_t  de_alu_op,
    input  wire rv_core_pkg::word_t    de_a,
    input  wire rv_core_pkg::word_t    de_b,
    input  wire rv_core_pkg::reg_idx_t de_rd,
    output rv_core_pkg::word_t         alu_result,
    output logic                       ex_valid,
    output logic                       ex_illegal,
    output rv_core_pkg::reg_idx_t      ex_rd,
    output rv_core_pkg::word_t         ex_value
);
    import rv_core_pkg::*;

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = de_b[SHAMT_W-1:0];
    assign lt_signed   = ($signed(de_a) < $signed(de_b));
    assign lt_unsigned = (de_a < de_b);

    always_comb begin
        case (de_alu_op)
            ALU_ADD: begin
                alu_result = de_a + de_b;
            end
            ALU_SUB: begin
                alu_result = de_a - de_b;
            end
            ALU_SLL: begin
                alu_result = de_a << shamt;
            end
            ALU_SLT: begin
                alu_result = {{(XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                alu_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_XOR: begin
                alu_result = de_a ^ de_b;
            end
            ALU_SRL: begin
                alu_result = de_a >> shamt;
            end
            ALU_SRA: begin
                // sign bit fills from the left
                alu_result = word_t'($signed(de_a) >>> shamt);
            end
            ALU_OR: begin
                alu_result = de_a | de_b;
            end
            ALU_AND: begin
                alu_result = de_a & de_b;
            end
            default: begin
                alu_result = de_b;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end
        else begin
            ex_valid <= de_valid;
        end
    end

    // result travels with its destination for forwarding and writeback
    always_ff @(posedge clk) begin
        if (de_valid) begin
            ex_illegal <= de_illegal;
            ex_rd      <= de_rd;
            ex_value   <= alu_result;
        end
    end

    illegal_has_no_rd : assert property (@(posedge clk) disable iff (!rst_n)
        de_valid && de_illegal |-> de_rd == '0);

endmodule : rv_execute

`default_nettype wire

/* logic/rv_decode.sv */
`default_nettype none

module rv_decode (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        inst_valid,
    input  wire rv_isa_pkg::inst_word_t inst,
    input  wire rv_core_pkg::word_t    alu_result,
    input  wire                        ex_valid,
    input  wire                        ex_illegal,
    input  wire rv_core_pkg::reg_idx_t ex_rd,
    input  wire rv_core_pkg::word_t    ex_value,
    input  wire rv_core_pkg::word_t    rs1_data,
    input  wire rv_core_pkg::word_t    rs2_data,
    output rv_core_pkg::reg_idx_t      rs1_idx,
    output rv_core_pkg::reg_idx_t      rs2_idx,
    output logic                       de_valid,
    output logic                       de_illegal,
    output rv_core_pkg::alu_op_t       de_alu_op,
    output rv_core_pkg::word_t         de_a,
    output rv_core_pkg::word_t         de_b,
    output rv_core_pkg::reg_idx_t      de_rd
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    logic [OPC_W-1:0] opcode;
    logic [F3_W-1:0]  funct3;
    logic [F7_W-1:0]  funct7;
    reg_idx_t         rd;
    logic             alt;
    logic             legal;
    logic             use_imm;
    alu_op_t          f3_op;
    alu_op_t          alu_op;
    word_t            imm;
    word_t            rs1_val;
    word_t            rs2_val;

    // newest producer wins: execute input, then execute register, then file
    function automatic word_t fwd_operand(input reg_idx_t src, input word_t rf_data);
        word_t val;
        val = rf_data;
        if (src != '0) begin
            if (de_valid && !de_illegal && de_rd == src) begin
                val = alu_result;
            end
            else if (ex_valid && !ex_illegal && ex_rd == src) begin
                val = ex_value;
            end
        end
        return val;
    endfunction

    assign opcode  = inst[OPC_W-1:0];
    assign rd      = inst[RD_LSB +: REG_FIELD_W];
    assign rs1_idx = inst[RS1_LSB +: REG_FIELD_W];
    assign rs2_idx = inst[RS2_LSB +: REG_FIELD_W];
    assign funct3  = inst[F3_LSB +: F3_W];
    assign funct7  = inst[F7_LSB +: F7_W];
    assign alt     = (funct7 == F7_ALT);

    // sign-extended I immediate, or U immediate for lui
    assign imm = (opcode == OPC_LUI) ?
                 {inst[IMM_U_LSB +: IMM_U_W], {IMM_U_LSB{1'b0}}} :
                 {{(XLEN-IMM_I_W){inst[INST_W-1]}}, inst[IMM_I_LSB +: IMM_I_W]};

    // funct3 to ALU op, sub only exists in the register form
    always_comb begin
        case (funct3)
            F3_ADD_SUB: f3_op = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
            F3_SLL:     f3_op = ALU_SLL;
            F3_SLT:     f3_op = ALU_SLT;
            F3_SLTU:    f3_op = ALU_SLTU;
            F3_XOR:     f3_op = ALU_XOR;
            F3_SR:      f3_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      f3_op = ALU_OR;
            default:    f3_op = ALU_AND;
        endcase
    end

    always_comb begin
        legal   = 1'b0;
        use_imm = 1'b0;
        alu_op  = f3_op;
        case (opcode)
            OPC_OP: begin
                legal = (funct7 == F7_BASE) ||
                        (alt && (funct3 == F3_ADD_SUB || funct3 == F3_SR));
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                // shift immediates reuse funct7 bits
                if (funct3 == F3_SLL) begin
                    legal = (funct7 == F7_BASE);
                end
                else if (funct3 == F3_SR) begin
                    legal = (funct7 == F7_BASE) || alt;
                end
                else begin
                    legal = 1'b1;
                end
            end
            OPC_LUI: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                alu_op  = ALU_PASS_B;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    always_comb begin
        rs1_val = fwd_operand(rs1_idx, rs1_data);
        rs2_val = fwd_operand(rs2_idx, rs2_data);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de_valid <= 1'b0;
        end
        else begin
            de_valid <= inst_valid;
        end
    end

    // illegal encodings carry rd of x0 so nothing downstream writes
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            de_illegal <= !legal;
            de_alu_op  <= alu_op;
            de_a       <= rs1_val;
            de_b       <= use_imm ? imm : rs2_val;
            de_rd      <= legal ? rd : '0;
        end
    end

    de_valid_known : assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(de_valid));

endmodule : rv_decode

`default_nettype wire

/* logic/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

    // data path width and register count
    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;

    // shift amount comes from the low bits of operand b
    localparam int SHAMT_W = $clog2(XLEN);

    typedef logic [XLEN-1:0] word_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

    // operations the execute stage knows
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // lui, operand b already holds the shifted immediate
        ALU_PASS_B
    } alu_op_t;

endpackage : rv_core_pkg

`default_nettype wire

/* logic/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // raw instruction word
    localparam int INST_W = 32;

    typedef logic [INST_W-1:0] inst_word_t;

    // field widths
    localparam int OPC_W       = 7;
    localparam int F3_W        = 3;
    localparam int F7_W        = 7;
    localparam int REG_FIELD_W = 5;

    // field positions, lsb of each field
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int F7_LSB  = 25;

    // immediate fields
    localparam int IMM_I_LSB = 20;
    localparam int IMM_I_W   = 12;
    localparam int IMM_U_LSB = 12;
    localparam int IMM_U_W   = 20;

    // major opcodes handled by this core
    localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;
    localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111;

    // funct3 for the integer ALU group
    localparam logic [F3_W-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [F3_W-1:0] F3_SLL     = 3'b001;
    localparam logic [F3_W-1:0] F3_SLT     = 3'b010;
    localparam logic [F3_W-1:0] F3_SLTU    = 3'b011;
    localparam logic [F3_W-1:0] F3_XOR     = 3'b100;
    localparam logic [F3_W-1:0] F3_SR      = 3'b101;
    localparam logic [F3_W-1:0] F3_OR      = 3'b110;
    localparam logic [F3_W-1:0] F3_AND     = 3'b111;

    // funct7, alt selects SUB and SRA
    localparam logic [F7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [F7_W-1:0] F7_ALT  = 7'b0100000;

endpackage : rv_isa_pkg

`default_nettype wire
